// File: flstory_pkg.sv
/*
 * Shared definitions for the CPU-to-CPU communication block.
 * Port select encoding, status byte layout and header bit positions,
 * taken by wildcard import in each module that needs them.
 */
`default_nettype none

package flstory_pkg;

    // main CPU port select, straight from bus_addr[1:0]
    typedef enum logic [1:0] {
        PORT_SND    = 2'd0,
        PORT_MCU    = 2'd1,
        PORT_STATUS = 2'd2,
        PORT_NONE   = 2'd3
    } io_port_e;

    // status byte layout, upper bits read as zero
    localparam int ST_SND_IBF = 0;
    localparam int ST_SND_OBF = 1;
    localparam int ST_MCU_IBF = 2;
    localparam int ST_MCU_OBF = 3;
    localparam int ST_COIN1   = 4;
    localparam int ST_COIN2   = 5;

    // cartridge header byte
    localparam int HDR_MCU_OFF = 0;
    localparam int HDR_COINXOR = 1;

endpackage

`default_nettype wire

// File: mbox_if.sv
/*
 * Main-side link between the I/O decoder and one mailbox.
 * The decoder issues one-cycle strobes and write data, the mailbox
 * returns its peer-to-main latch and both flag levels.
 */
`timescale 1ns/100ps
`default_nettype none

interface mbox_if #(
    parameter int DW = 8
) ();

    logic          wr;
    logic          rd;
    logic [DW-1:0] wdata;
    logic [DW-1:0] rdata;
    logic          ibf;
    logic          obf;

    modport decoder (
        output wr, rd, wdata,
        input  rdata, ibf, obf
    );

    modport mailbox (
        input  wr, rd, wdata,
        output rdata, ibf, obf
    );

endinterface

`default_nettype wire

// File: flstory_header.sv
/*
 * Cartridge header register, loaded during ROM download.
 * Captures offset zero of the header stream and gives out the
 * configuration bits used by the communication block.
 */
`timescale 1ns/100ps
`default_nettype none

module flstory_header import flstory_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       header,
    input  logic       prog_we,
    input  logic [2:0] prog_addr,
    input  logic [7:0] prog_data,
    output logic       mcu_off,
    output logic       coinxor
);

    logic hdr_we;

    // only the first header byte holds our bits
    assign hdr_we = header && prog_we && (prog_addr == 3'd0);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mcu_off <= 1'b0;
            coinxor <= 1'b0;
        end else if (hdr_we) begin
            mcu_off <= prog_data[HDR_MCU_OFF];
            coinxor <= prog_data[HDR_COINXOR];
        end
    end

endmodule

`default_nettype wire

// File: flstory_mailbox.sv
/*
 * Bidirectional mailbox between the main CPU and one peer CPU.
 * Two data latches with input and output buffer full flags.
 * hold_clear keeps the mailbox empty and ignores writes from both sides.
 */
`timescale 1ns/100ps
`default_nettype none

module flstory_mailbox #(
    parameter int DW = 8
) (
    input  logic          clk,
    input  logic          arst_n,
    input  logic          hold_clear,
    mbox_if.mailbox       main,
    input  logic          peer_wr,
    input  logic          peer_rd,
    input  logic [DW-1:0] peer_din,
    output logic [DW-1:0] peer_dout,
    output logic          peer_ibf,
    output logic          peer_obf
);

    logic [DW-1:0] m2p_data;
    logic [DW-1:0] p2m_data;
    logic          ibf;
    logic          obf;

    // data latches, a write to a full latch simply overwrites it
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            m2p_data <= '0;
            p2m_data <= '0;
        end else begin
            if (main.wr && !hold_clear) begin
                m2p_data <= main.wdata;
            end
            if (peer_wr && !hold_clear) begin
                p2m_data <= peer_din;
            end
        end
    end

    // flags, set has priority over clear on the same edge
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ibf <= 1'b0;
            obf <= 1'b0;
        end else if (hold_clear) begin
            ibf <= 1'b0;
            obf <= 1'b0;
        end else begin
            if (main.wr) begin
                ibf <= 1'b1;
            end else if (peer_rd) begin
                ibf <= 1'b0;
            end
            if (peer_wr) begin
                obf <= 1'b1;
            end else if (main.rd) begin
                obf <= 1'b0;
            end
        end
    end

    assign main.rdata = p2m_data;
    assign main.ibf   = ibf;
    assign main.obf   = obf;

    assign peer_dout  = m2p_data;
    assign peer_ibf   = ibf;
    assign peer_obf   = obf;

endmodule

`default_nettype wire

// File: flstory_io_decode.sv
/*
 * Main CPU I/O decoder for the communication ports.
 * Routes write and read strobes to the addressed mailbox, builds the
 * status byte and registers the selected read data onto bus_din.
 */
`timescale 1ns/100ps
`default_nettype none

module flstory_io_decode import flstory_pkg::*; #(
    parameter int DW = 8
) (
    input  logic          clk,
    input  logic          arst_n,
    input  logic          bus_cs,
    input  logic          bus_wr,
    input  logic          bus_rd,
    input  logic [1:0]    bus_addr,
    input  logic [DW-1:0] bus_dout,
    output logic [DW-1:0] bus_din,
    input  logic [1:0]    coin,
    input  logic          coinxor,
    mbox_if.decoder       snd,
    mbox_if.decoder       mcu
);

    io_port_e      port;
    logic          wr_en;
    logic          rd_en;
    logic [1:0]    coin_eff;
    logic [DW-1:0] status;
    logic [DW-1:0] rd_mux;

    assign port  = io_port_e'(bus_addr);
    assign wr_en = bus_cs && bus_wr;
    assign rd_en = bus_cs && bus_rd;

    // strobes go only to the addressed mailbox
    assign snd.wr    = wr_en && (port == PORT_SND);
    assign snd.rd    = rd_en && (port == PORT_SND);
    assign mcu.wr    = wr_en && (port == PORT_MCU);
    assign mcu.rd    = rd_en && (port == PORT_MCU);
    assign snd.wdata = bus_dout;
    assign mcu.wdata = bus_dout;

    // some boards have active-low coin switches
    assign coin_eff = coin ^ {2{coinxor}};

    always_comb begin
        status             = '0;
        status[ST_SND_IBF] = snd.ibf;
        status[ST_SND_OBF] = snd.obf;
        status[ST_MCU_IBF] = mcu.ibf;
        status[ST_MCU_OBF] = mcu.obf;
        status[ST_COIN1]   = coin_eff[0];
        status[ST_COIN2]   = coin_eff[1];
    end

    always_comb begin
        case (port)
            PORT_SND:    rd_mux = snd.rdata;
            PORT_MCU:    rd_mux = mcu.rdata;
            PORT_STATUS: rd_mux = status;
            default:     rd_mux = '0;
        endcase
    end

    // bus_din holds until the next read
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            bus_din <= '0;
        end else if (rd_en) begin
            bus_din <= rd_mux;
        end
    end

endmodule

`default_nettype wire

// File: flstory_comm.sv
/*
 * Top level of the CPU-to-CPU communication block.
 * Joins the header register, the sound and MCU mailboxes and the
 * main CPU I/O decoder behind plain ports.
 */
`timescale 1ns/100ps
`default_nettype none

module flstory_comm #(
    parameter int DW = 8
) (
    input  logic          clk,
    input  logic          arst_n,
    // main CPU bus
    input  logic          bus_cs,
    input  logic          bus_wr,
    input  logic          bus_rd,
    input  logic [1:0]    bus_addr,
    input  logic [DW-1:0] bus_dout,
    output logic [DW-1:0] bus_din,
    // sound CPU side
    input  logic          snd_wr,
    input  logic          snd_rd,
    input  logic [DW-1:0] snd_din,
    output logic [DW-1:0] snd_dout,
    output logic          snd_ibf,
    output logic          snd_obf,
    // MCU side
    input  logic          mcu_wr,
    input  logic          mcu_rd,
    input  logic [DW-1:0] mcu_din,
    output logic [DW-1:0] mcu_dout,
    output logic          mcu_ibf,
    output logic          mcu_obf,
    // header download
    input  logic          header,
    input  logic          prog_we,
    input  logic [2:0]    prog_addr,
    input  logic [7:0]    prog_data,
    input  logic [1:0]    coin,
    output logic          mcu_off,
    output logic          coinxor
);

    mbox_if #(.DW(DW)) snd_if ();
    mbox_if #(.DW(DW)) mcu_if ();

    flstory_header u_header (
        .clk       ( clk       ),
        .arst_n    ( arst_n    ),
        .header    ( header    ),
        .prog_we   ( prog_we   ),
        .prog_addr ( prog_addr ),
        .prog_data ( prog_data ),
        .mcu_off   ( mcu_off   ),
        .coinxor   ( coinxor   )
    );

    // sound CPU is always fitted
    flstory_mailbox #(.DW(DW)) u_snd_mbox (
        .clk        ( clk      ),
        .arst_n     ( arst_n   ),
        .hold_clear ( 1'b0     ),
        .main       ( snd_if   ),
        .peer_wr    ( snd_wr   ),
        .peer_rd    ( snd_rd   ),
        .peer_din   ( snd_din  ),
        .peer_dout  ( snd_dout ),
        .peer_ibf   ( snd_ibf  ),
        .peer_obf   ( snd_obf  )
    );

    flstory_mailbox #(.DW(DW)) u_mcu_mbox (
        .clk        ( clk      ),
        .arst_n     ( arst_n   ),
        .hold_clear ( mcu_off  ),
        .main       ( mcu_if   ),
        .peer_wr    ( mcu_wr   ),
        .peer_rd    ( mcu_rd   ),
        .peer_din   ( mcu_din  ),
        .peer_dout  ( mcu_dout ),
        .peer_ibf   ( mcu_ibf  ),
        .peer_obf   ( mcu_obf  )
    );

    flstory_io_decode #(.DW(DW)) u_io (
        .clk      ( clk      ),
        .arst_n   ( arst_n   ),
        .bus_cs   ( bus_cs   ),
        .bus_wr   ( bus_wr   ),
        .bus_rd   ( bus_rd   ),
        .bus_addr ( bus_addr ),
        .bus_dout ( bus_dout ),
        .bus_din  ( bus_din  ),
        .coin     ( coin     ),
        .coinxor  ( coinxor  ),
        .snd      ( snd_if   ),
        .mcu      ( mcu_if   )
    );

endmodule

`default_nettype wire

// File: flstory_checker.sv
/*
 * Checker for the communication block. Keeps a shadow model of the
 * latches, flags and header bits, updated on each rising edge, and
 * compares the DUT outputs on the falling edge.
 */
`timescale 1ns/100ps
`default_nettype none

module flstory_checker import flstory_pkg::*; #(
    parameter int DW = 8
) (
    input  logic          clk,
    input  logic          arst_n,
    input  logic          bus_cs,
    input  logic          bus_wr,
    input  logic          bus_rd,
    input  logic [1:0]    bus_addr,
    input  logic [DW-1:0] bus_dout,
    input  logic [DW-1:0] bus_din,
    input  logic          snd_wr,
    input  logic          snd_rd,
    input  logic [DW-1:0] snd_din,
    input  logic [DW-1:0] snd_dout,
    input  logic          snd_ibf,
    input  logic          snd_obf,
    input  logic          mcu_wr,
    input  logic          mcu_rd,
    input  logic [DW-1:0] mcu_din,
    input  logic [DW-1:0] mcu_dout,
    input  logic          mcu_ibf,
    input  logic          mcu_obf,
    input  logic          header,
    input  logic          prog_we,
    input  logic [2:0]    prog_addr,
    input  logic [7:0]    prog_data,
    input  logic [1:0]    coin,
    input  logic          mcu_off,
    input  logic          coinxor,
    output int            err_count
);

    logic [DW-1:0] sh_snd_m2p, sh_snd_p2m, sh_mcu_m2p, sh_mcu_p2m, sh_din;
    logic          sh_snd_ibf, sh_snd_obf, sh_mcu_ibf, sh_mcu_obf;
    logic          sh_off, sh_inv;
    logic          main_wr;
    logic          main_rd;
    int            errors = 0;

    assign main_wr   = bus_cs && bus_wr;
    assign main_rd   = bus_cs && bus_rd;
    assign err_count = errors;

    // expected read data, built from the shadow state before the edge
    function automatic logic [DW-1:0] expect_read(input logic [1:0] addr);
        logic [DW-1:0] st;
        st             = '0;
        st[ST_SND_IBF] = sh_snd_ibf;
        st[ST_SND_OBF] = sh_snd_obf;
        st[ST_MCU_IBF] = sh_mcu_ibf;
        st[ST_MCU_OBF] = sh_mcu_obf;
        st[ST_COIN1]   = coin[0] ^ sh_inv;
        st[ST_COIN2]   = coin[1] ^ sh_inv;
        case (addr)
            PORT_SND:    expect_read = sh_snd_p2m;
            PORT_MCU:    expect_read = sh_mcu_p2m;
            PORT_STATUS: expect_read = st;
            default:     expect_read = '0;
        endcase
    endfunction

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sh_snd_m2p <= '0;
            sh_snd_p2m <= '0;
            sh_mcu_m2p <= '0;
            sh_mcu_p2m <= '0;
            sh_din     <= '0;
            sh_snd_ibf <= 1'b0;
            sh_snd_obf <= 1'b0;
            sh_mcu_ibf <= 1'b0;
            sh_mcu_obf <= 1'b0;
            sh_off     <= 1'b0;
            sh_inv     <= 1'b0;
        end else begin
            // sound mailbox, a set beats a clear
            if (main_wr && bus_addr == PORT_SND) begin
                sh_snd_m2p <= bus_dout;
                sh_snd_ibf <= 1'b1;
            end else if (snd_rd) begin
                sh_snd_ibf <= 1'b0;
            end
            if (snd_wr) begin
                sh_snd_p2m <= snd_din;
                sh_snd_obf <= 1'b1;
            end else if (main_rd && bus_addr == PORT_SND) begin
                sh_snd_obf <= 1'b0;
            end
            // MCU mailbox is frozen empty while the MCU is absent
            if (sh_off) begin
                sh_mcu_ibf <= 1'b0;
                sh_mcu_obf <= 1'b0;
            end else begin
                if (main_wr && bus_addr == PORT_MCU) begin
                    sh_mcu_m2p <= bus_dout;
                    sh_mcu_ibf <= 1'b1;
                end else if (mcu_rd) begin
                    sh_mcu_ibf <= 1'b0;
                end
                if (mcu_wr) begin
                    sh_mcu_p2m <= mcu_din;
                    sh_mcu_obf <= 1'b1;
                end else if (main_rd && bus_addr == PORT_MCU) begin
                    sh_mcu_obf <= 1'b0;
                end
            end
            if (main_rd) begin
                sh_din <= expect_read(bus_addr);
            end
            if (header && prog_we && prog_addr == 3'd0) begin
                sh_off <= prog_data[HDR_MCU_OFF];
                sh_inv <= prog_data[HDR_COINXOR];
            end
        end
    end

    task automatic check_value(input string name, input logic [DW-1:0] exp,
                               input logic [DW-1:0] act);
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %s expected 0x%0h actual 0x%0h at %0t", name, exp, act, $time);
        end
    endtask

    // outputs are all registered, so they are settled at the falling edge
    always @(negedge clk) begin
        if (arst_n) begin
            check_value("bus_din", sh_din, bus_din);
            check_value("snd_dout", sh_snd_m2p, snd_dout);
            check_value("mcu_dout", sh_mcu_m2p, mcu_dout);
            check_value("snd_ibf", DW'(sh_snd_ibf), DW'(snd_ibf));
            check_value("snd_obf", DW'(sh_snd_obf), DW'(snd_obf));
            check_value("mcu_ibf", DW'(sh_mcu_ibf), DW'(mcu_ibf));
            check_value("mcu_obf", DW'(sh_mcu_obf), DW'(mcu_obf));
            check_value("mcu_off", DW'(sh_off), DW'(mcu_off));
            check_value("coinxor", DW'(sh_inv), DW'(coinxor));
        end
    end

endmodule

`default_nettype wire

// File: tb_flstory_comm.sv
/*
 * Testbench for the communication block. Loads the header, runs directed
 * mailbox sequences and random strobes on the falling clock edge, while
 * the checker compares the DUT against its shadow model.
 */
`timescale 1ns/100ps
`default_nettype none

module tb_flstory_comm import flstory_pkg::*; ();

    localparam int DW      = 8;
    localparam int TIMEOUT = 20;

    logic          clk, arst_n;
    logic          bus_cs, bus_wr, bus_rd;
    logic [1:0]    bus_addr, coin;
    logic [DW-1:0] bus_dout, bus_din;
    logic          snd_wr, snd_rd, snd_ibf, snd_obf;
    logic          mcu_wr, mcu_rd, mcu_ibf, mcu_obf;
    logic [DW-1:0] snd_din, snd_dout, mcu_din, mcu_dout;
    logic          header, prog_we, mcu_off, coinxor;
    logic [2:0]    prog_addr;
    logic [7:0]    prog_data;
    logic [31:0]   seed_val;
    int            errors;
    int            timeouts;

    flstory_comm #(.DW(DW)) u_dut (.*);

    flstory_checker #(.DW(DW)) u_checker (.*, .err_count(errors));

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic level_of(input int sel);
        case (sel)
            0:       level_of = snd_ibf;
            1:       level_of = snd_obf;
            2:       level_of = mcu_ibf;
            3:       level_of = mcu_obf;
            4:       level_of = mcu_off;
            default: level_of = coinxor;
        endcase
    endfunction

    task automatic wait_level(input int sel, input logic val, input string name);
        int n;
        n = 0;
        while (level_of(sel) !== val && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (level_of(sel) !== val) begin
            timeouts++;
            $display("timeout: %s did not reach %0d within %0d cycles", name, val, TIMEOUT);
        end
    endtask

    task automatic clear_strobes();
        bus_cs = 1'b0;
        bus_wr = 1'b0;
        bus_rd = 1'b0;
        {mcu_rd, mcu_wr, snd_rd, snd_wr} = 4'b0000;
    endtask

    // peer strobes packed as {mcu_rd, mcu_wr, snd_rd, snd_wr}
    task automatic drive_cycle(input logic wr, input logic rd, input logic [1:0] addr,
                               input logic [DW-1:0] data, input logic [3:0] peer);
        @(negedge clk);
        bus_cs   = wr | rd;
        bus_wr   = wr;
        bus_rd   = rd;
        bus_addr = addr;
        bus_dout = data;
        snd_din  = ~data;
        mcu_din  = data + 1'b1;
        {mcu_rd, mcu_wr, snd_rd, snd_wr} = peer;
        @(negedge clk);
        clear_strobes();
    endtask

    task automatic load_header(input logic [7:0] cfg);
        @(negedge clk);
        header    = 1'b1;
        prog_we   = 1'b1;
        prog_addr = 3'd0;
        prog_data = cfg;
        // later header bytes leave the configuration alone
        @(negedge clk);
        prog_addr = 3'd1;
        prog_data = ~cfg;
        // nor does offset zero outside the header stream
        @(negedge clk);
        header    = 1'b0;
        prog_addr = 3'd0;
        @(negedge clk);
        prog_we = 1'b0;
    endtask

    task automatic random_cycles(input int n);
        logic [31:0] r;
        logic [31:0] d;
        repeat (n) begin
            @(negedge clk);
            r        = $urandom;
            d        = $urandom;
            bus_cs   = r[0];
            bus_wr   = r[1] & ~r[2];
            bus_rd   = r[2] & ~r[1];
            bus_addr = r[4:3];
            {mcu_rd, mcu_wr, snd_rd, snd_wr} = r[8:5] & r[12:9];
            coin     = r[14:13];
            bus_dout = d[7:0];
            snd_din  = d[15:8];
            mcu_din  = d[23:16];
        end
        @(negedge clk);
        clear_strobes();
    endtask

    initial begin
        seed_val  = $urandom(62);
        timeouts  = 0;
        arst_n    = 1'b0;
        clear_strobes();
        bus_addr  = 2'd0;
        bus_dout  = '0;
        snd_din   = '0;
        mcu_din   = '0;
        header    = 1'b0;
        prog_we   = 1'b0;
        prog_addr = 3'd0;
        prog_data = 8'h00;
        coin      = 2'b01;
        repeat (16) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);

        // MCU fitted and coins straight with unused header bits set
        load_header(8'hfc);

        drive_cycle(1'b1, 1'b0, PORT_SND, 8'ha5, 4'b0000);
        wait_level(0, 1'b1, "snd_ibf");
        drive_cycle(1'b0, 1'b0, PORT_SND, 8'h00, 4'b0010);
        wait_level(0, 1'b0, "snd_ibf");
        drive_cycle(1'b1, 1'b0, PORT_MCU, 8'h3c, 4'b0000);
        wait_level(2, 1'b1, "mcu_ibf");
        drive_cycle(1'b0, 1'b0, PORT_MCU, 8'h00, 4'b1000);
        wait_level(2, 1'b0, "mcu_ibf");
        drive_cycle(1'b0, 1'b0, PORT_SND, 8'h71, 4'b0001);
        wait_level(1, 1'b1, "snd_obf");
        drive_cycle(1'b0, 1'b1, PORT_SND, 8'h00, 4'b0000);
        wait_level(1, 1'b0, "snd_obf");
        drive_cycle(1'b0, 1'b0, PORT_MCU, 8'h96, 4'b0100);
        wait_level(3, 1'b1, "mcu_obf");
        drive_cycle(1'b0, 1'b1, PORT_MCU, 8'h00, 4'b0000);
        wait_level(3, 1'b0, "mcu_obf");
        drive_cycle(1'b0, 1'b1, PORT_NONE, 8'h00, 4'b0000);

        // set and clear of one flag on the same edge
        drive_cycle(1'b1, 1'b0, PORT_SND, 8'h11, 4'b0010);
        drive_cycle(1'b0, 1'b1, PORT_MCU, 8'h22, 4'b0100);
        wait_level(0, 1'b1, "snd_ibf");
        wait_level(3, 1'b1, "mcu_obf");
        drive_cycle(1'b0, 1'b1, PORT_STATUS, 8'h00, 4'b0000);

        random_cycles(2000);

        // MCU absent and coins inverted
        load_header(8'h03);
        wait_level(4, 1'b1, "mcu_off");
        wait_level(5, 1'b1, "coinxor");
        drive_cycle(1'b1, 1'b0, PORT_MCU, 8'h5a, 4'b0100);
        wait_level(2, 1'b0, "mcu_ibf");
        wait_level(3, 1'b0, "mcu_obf");
        drive_cycle(1'b1, 1'b0, PORT_SND, 8'h99, 4'b0000);
        wait_level(0, 1'b1, "snd_ibf");
        drive_cycle(1'b0, 1'b1, PORT_STATUS, 8'h00, 4'b0000);

        random_cycles(1000);
        repeat (2) @(negedge clk);

        $display("run complete: %0d errors, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
flstory_pkg.sv
mbox_if.sv
flstory_header.sv
flstory_mailbox.sv
flstory_io_decode.sv
flstory_comm.sv
flstory_checker.sv
tb_flstory_comm.sv

// File: run.sh
#!/bin/sh
# build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_flstory_comm -f tb.f -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -F -q "*** FAILED ***" sim.log; then
    exit 1
fi
exit 0
